// ==== all.f ====
+incdir+source
source/xlat_pkg.sv
source/access_timer.sv
source/read_return_pipe.sv
source/slave_translator.sv
testbench/xlat_properties.sv
testbench/xlat_checker.sv
testbench/tb_slave_translator.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds the testbench with Verilator, runs it and scans the log for a failure
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_slave_translator -f all.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || {
   cat sim.log
   echo "simulator exited with an error status"
   exit 1
}
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
   echo "simulation failed"
   exit 1
fi
echo "simulation passed"

// ==== testbench/tb_slave_translator.sv ====
// slave model holds 16 words and aliases above them; the master issues one access at a time
`timescale 1ns/1ps
`include "xlat_config.svh"

module tb_slave_translator;

   localparam int CLK_PERIOD   = 40;
   localparam int RESET_CYCLES = 10;
   localparam int MEM_WORDS    = 16;
   localparam int MEM_IDX_W    = $clog2(MEM_WORDS);
   localparam int N_PARTIAL    = 8;
   localparam int N_RANDOM     = 60;
   localparam int N_ACCESSES   = MEM_WORDS + 2 * N_PARTIAL + N_RANDOM;
   localparam int MAX_GAP      = 3;
   localparam int RD_LEN       = `XLAT_SETUP_CYCLES + `XLAT_READ_WAIT_CYCLES + 1;
   localparam int WR_LEN       = `XLAT_SETUP_CYCLES + `XLAT_WRITE_WAIT_CYCLES +
                                 `XLAT_HOLD_CYCLES + 1;
   localparam int LONGEST      = (RD_LEN > WR_LEN) ? RD_LEN : WR_LEN;
   localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES +
                                    N_ACCESSES * (LONGEST + `XLAT_READ_LATENCY + MAX_GAP));
   localparam xlat_pkg::uav_addr_t UAV_BASE = 32'h4000_0000;

   logic                 clk = 1'b0;
   logic                 reset;
   xlat_pkg::uav_addr_t  uav_address;
   xlat_pkg::data_t      uav_writedata, uav_readdata, av_writedata, av_readdata;
   xlat_pkg::byteen_t    uav_byteenable, av_byteenable, av_writebyteenable;
   xlat_pkg::av_addr_t   av_address;
   logic                 uav_read, uav_write, uav_waitrequest, uav_readdatavalid;
   logic                 av_read, av_write, av_begintransfer;
   int                   seed;
   int                   stall_errors;
   int                   error_count, check_count, pending_reads;
   xlat_pkg::data_t      slave_mem [0:MEM_WORDS-1];
   logic [MEM_IDX_W-1:0] rd_idx_pipe [0:`XLAT_READ_LATENCY-1];

   slave_translator u_slave_translator (.*);

   xlat_checker u_xlat_checker (.*);

   bind slave_translator xlat_properties u_xlat_properties (
      .clk               (clk),
      .reset             (reset),
      .uav_read          (uav_read),
      .uav_write         (uav_write),
      .uav_readdatavalid (uav_readdatavalid),
      .av_read           (av_read),
      .av_write          (av_write),
      .av_begintransfer  (av_begintransfer)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   // ------------------------------------------------------------------------
   // downstream slave, data follows the last av_read cycle by the latency
   // ------------------------------------------------------------------------
   assign av_readdata = slave_mem[rd_idx_pipe[`XLAT_READ_LATENCY-1]];

   always @(posedge clk) begin
      for (int b = 0; b < `XLAT_SYMBOLS_PER_WORD; b++)
         if (av_write && av_writebyteenable[b])
            slave_mem[av_address[MEM_IDX_W-1:0]][8*b +: 8] <= av_writedata[8*b +: 8];
      rd_idx_pipe[0] <= av_read ? av_address[MEM_IDX_W-1:0] : '0;
      for (int s = 1; s < `XLAT_READ_LATENCY; s++)
         rd_idx_pipe[s] <= rd_idx_pipe[s-1];
   end

   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("timeout: run did not finish within %0d clock cycles", WATCHDOG_CYCLES);
      $display("CHECKS FAILED");
      $finish;
   end

   // one upstream access from a falling edge until waitrequest drops
   task automatic run_access(input logic is_write, input logic [MEM_IDX_W-1:0] word,
                             input xlat_pkg::data_t data, input xlat_pkg::byteen_t be);
      int waited;
      waited         = 0;
      uav_read       = ~is_write;
      uav_write      = is_write;
      uav_address    = UAV_BASE | (xlat_pkg::uav_addr_t'(word) << `XLAT_WORD_SHIFT) |
                       xlat_pkg::uav_addr_t'($unsigned($random(seed)) % `XLAT_SYMBOLS_PER_WORD);
      uav_writedata  = data;
      uav_byteenable = be;
      @(posedge clk);
      while (uav_waitrequest && waited < 4 * LONGEST) begin
         waited++;
         @(posedge clk);
      end
      if (uav_waitrequest) begin
         stall_errors++;
         $display("access to word %0d never saw waitrequest drop", word);
      end
      @(negedge clk);
      uav_read  = 1'b0;
      uav_write = 1'b0;
   endtask

   initial begin
      logic [MEM_IDX_W-1:0] word;
      xlat_pkg::byteen_t    be;
      seed           = 32'h6f59;
      stall_errors   = 0;
      reset          = 1'b1;
      uav_address    = '0;
      uav_writedata  = '0;
      uav_byteenable = '0;
      uav_read       = 1'b0;
      uav_write      = 1'b0;
      for (int i = 0; i < MEM_WORDS; i++)
         slave_mem[i] = 32'h5a00_0000 ^ (i * 32'h0013_0701);
      for (int s = 0; s < `XLAT_READ_LATENCY; s++)
         rd_idx_pipe[s] = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      reset = 1'b0;

      // first write already waits during the reset override cycle
      for (int w = 0; w < MEM_WORDS; w++)
         run_access(1'b1, MEM_IDX_W'(w), $random(seed), '1);

      // partial writes, each read back at once
      for (int n = 0; n < N_PARTIAL; n++) begin
         word = MEM_IDX_W'($unsigned($random(seed)));
         be   = xlat_pkg::byteen_t'($unsigned($random(seed)));
         if (be == '0)
            be = xlat_pkg::byteen_t'(2);
         run_access(1'b1, word, $random(seed), be);
         run_access(1'b0, word, '0, '1);
      end

      for (int n = 0; n < N_RANDOM; n++) begin
         word = MEM_IDX_W'($unsigned($random(seed)));
         be   = xlat_pkg::byteen_t'($unsigned($random(seed)));
         run_access(1'($unsigned($random(seed)) % 2), word, $random(seed), be);
         repeat ($unsigned($random(seed)) % (MAX_GAP + 1)) @(negedge clk);
      end

      // room for the last read to return
      repeat (`XLAT_READ_LATENCY + 2) @(negedge clk);
      if (pending_reads != 0)
         $display("%0d reads never returned readdatavalid", pending_reads);
      $display("checks %0d, errors %0d, stalled accesses %0d, reads outstanding %0d",
               check_count, error_count, stall_errors, pending_reads);
      if (error_count == 0 && stall_errors == 0 && pending_reads == 0)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

// ==== testbench/xlat_checker.sv ====
// assumes one access at a time from the master; a read of a never-written word expects x
`timescale 1ns/1ps
`include "xlat_config.svh"

module xlat_checker (
   input  logic                clk,
   input  logic                reset,
   input  xlat_pkg::uav_addr_t uav_address,
   input  xlat_pkg::data_t     uav_writedata,
   input  xlat_pkg::byteen_t   uav_byteenable,
   input  logic                uav_read,
   input  logic                uav_write,
   input  logic                uav_waitrequest,
   input  logic                uav_readdatavalid,
   input  xlat_pkg::data_t     uav_readdata,
   input  xlat_pkg::av_addr_t  av_address,
   input  xlat_pkg::data_t     av_writedata,
   input  xlat_pkg::byteen_t   av_byteenable,
   input  xlat_pkg::byteen_t   av_writebyteenable,
   input  logic                av_read,
   input  logic                av_write,
   input  logic                av_begintransfer,
   output int                  error_count,
   output int                  check_count,
   output int                  pending_reads
);

   localparam int WR_LAST = `XLAT_SETUP_CYCLES + `XLAT_WRITE_WAIT_CYCLES;

   xlat_pkg::data_t        shadow [xlat_pkg::av_addr_t];
   xlat_pkg::data_t        exp_data_q [$];
   int                     due_q [$];
   xlat_pkg::access_kind_e kind;
   xlat_pkg::av_addr_t     word_addr;
   int                     idx;
   int                     cycle_no;
   logic                   first_cycle;

   // ------------------------------------------------------------------------
   // reference model
   // ------------------------------------------------------------------------
   // waitrequest drops only in the last cycle
   function automatic int access_len(input xlat_pkg::access_kind_e kd);
      if (kd == xlat_pkg::ACC_READ)
         return `XLAT_SETUP_CYCLES + `XLAT_READ_WAIT_CYCLES + 1;
      return `XLAT_SETUP_CYCLES + `XLAT_WRITE_WAIT_CYCLES + `XLAT_HOLD_CYCLES + 1;
   endfunction

   function automatic xlat_pkg::data_t merge_write(input xlat_pkg::data_t old_word,
                                                   input xlat_pkg::data_t new_word,
                                                   input xlat_pkg::byteen_t be);
      xlat_pkg::data_t merged;
      merged = old_word;
      for (int b = 0; b < `XLAT_SYMBOLS_PER_WORD; b++)
         if (be[b])
            merged[8*b +: 8] = new_word[8*b +: 8];
      return merged;
   endfunction

   function xlat_pkg::data_t expected_read(input xlat_pkg::av_addr_t addr);
      return shadow.exists(addr) ? shadow[addr] : 'x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("[ERROR] %0t %s: expected %h, actual %h", $time, name, expected, actual);
      end
   endtask

   // ------------------------------------------------------------------------
   // compare process
   // ------------------------------------------------------------------------
   always @(posedge clk) begin
      if (reset) begin
         first_cycle   = 1'b1;
         idx           = 0;
         cycle_no      = 0;
         error_count   = 0;
         check_count   = 0;
         pending_reads = 0;
      end else begin
         cycle_no++;
         if (first_cycle) begin
            // reset override cycle, a waiting request must not start yet
            check_value("uav_waitrequest", 32'(1'b1), 32'(uav_waitrequest));
            check_value("av_begintransfer", 32'(1'b0), 32'(av_begintransfer));
            check_value("av_read", 32'(1'b0), 32'(av_read));
            check_value("av_write", 32'(1'b0), 32'(av_write));
            check_value("uav_readdatavalid", 32'(1'b0), 32'(uav_readdatavalid));
            first_cycle = 1'b0;
         end else if (uav_read || uav_write) begin
            kind      = uav_write ? xlat_pkg::ACC_WRITE : xlat_pkg::ACC_READ;
            word_addr = xlat_pkg::av_addr_t'(uav_address >> `XLAT_WORD_SHIFT);
            check_value("uav_waitrequest", 32'(idx != access_len(kind) - 1),
                        32'(uav_waitrequest));
            check_value("av_begintransfer", 32'(idx == 0), 32'(av_begintransfer));
            check_value("av_read", 32'(uav_read && idx >= `XLAT_SETUP_CYCLES), 32'(av_read));
            check_value("av_write", 32'(uav_write && idx >= `XLAT_SETUP_CYCLES &&
                                        idx <= WR_LAST), 32'(av_write));
            // downstream address and enables follow the held request
            check_value("av_address", 32'(word_addr), 32'(av_address));
            check_value("av_byteenable", 32'(uav_byteenable), 32'(av_byteenable));
            check_value("av_writebyteenable",
                        uav_write ? 32'(uav_byteenable) : 32'(0),
                        32'(av_writebyteenable));
            if (uav_write)
               check_value("av_writedata", uav_writedata, av_writedata);
            if (uav_waitrequest) begin
               idx++;
            end else begin
               idx = 0;
               if (uav_write) begin
                  shadow[word_addr] = merge_write(expected_read(word_addr), uav_writedata,
                                                  uav_byteenable);
               end else begin
                  exp_data_q.push_back(expected_read(word_addr));
                  due_q.push_back(cycle_no + `XLAT_READ_LATENCY);
               end
            end
         end else begin
            check_value("av_begintransfer", 32'(1'b0), 32'(av_begintransfer));
         end
         if (uav_readdatavalid) begin
            if (exp_data_q.size() == 0) begin
               error_count++;
               $display("readdatavalid at %0t with no read outstanding", $time);
            end else begin
               check_value("uav_readdata", exp_data_q.pop_front(), uav_readdata);
               if (due_q.pop_front() != cycle_no) begin
                  error_count++;
                  $display("readdatavalid at %0t does not follow its read by the latency",
                           $time);
               end
            end
         end
         pending_reads = exp_data_q.size();
      end
   end

endmodule

// ==== testbench/xlat_properties.sv ====
// sampled on rising clock edges only; readdatavalid is checked on clocks seen during reset
`timescale 1ns/1ps

module xlat_properties (
   input logic clk,
   input logic reset,
   input logic uav_read,
   input logic uav_write,
   input logic uav_readdatavalid,
   input logic av_read,
   input logic av_write,
   input logic av_begintransfer
);

   // one downstream strobe at a time
   a_read_write_exclusive: assert property (@(posedge clk) disable iff (reset)
                                            !(av_read && av_write))
      else $error("av_read and av_write are high together");

   a_begin_has_request: assert property (@(posedge clk) disable iff (reset)
                                         av_begintransfer |-> (uav_read || uav_write))
      else $error("av_begintransfer without an upstream read or write");

   a_no_valid_in_reset: assert property (@(posedge clk) reset |-> !uav_readdatavalid)
      else $error("readdatavalid high during reset");

endmodule

// ==== source/slave_translator.sv ====
// single-word accesses only, no bursts; the slave must meet the configured fixed timing
`timescale 1ns/1ps
`include "xlat_config.svh"

module slave_translator (
   input  logic                clk,
   input  logic                reset,

   // upstream byte-addressed side
   input  xlat_pkg::uav_addr_t uav_address,
   input  xlat_pkg::data_t     uav_writedata,
   input  logic                uav_read,
   input  logic                uav_write,
   input  xlat_pkg::byteen_t   uav_byteenable,
   output logic                uav_waitrequest,
   output xlat_pkg::data_t     uav_readdata,
   output logic                uav_readdatavalid,

   // downstream word-addressed side
   output xlat_pkg::av_addr_t  av_address,
   output xlat_pkg::data_t     av_writedata,
   output logic                av_read,
   output logic                av_write,
   output xlat_pkg::byteen_t   av_byteenable,
   output xlat_pkg::byteen_t   av_writebyteenable,
   output logic                av_begintransfer,
   input  xlat_pkg::data_t     av_readdata
);

   // completing read, one cycle wide
   logic read_accepted;

   // ------------------------------------------------------------------------
   // address and data path
   // ------------------------------------------------------------------------
   // drop the byte offset bits
   assign av_address    = uav_address[`XLAT_WORD_SHIFT +: `XLAT_AV_ADDR_W];
   assign av_writedata  = uav_writedata;
   assign av_byteenable = uav_byteenable;

   // slave data arrives already aligned with readdatavalid
   assign uav_readdata  = av_readdata;

   // ------------------------------------------------------------------------
   // request timing
   // ------------------------------------------------------------------------
   access_timer u_access_timer (
      .clk                (clk),
      .reset              (reset),
      .read               (uav_read),
      .write              (uav_write),
      .byteenable         (uav_byteenable),
      .waitrequest        (uav_waitrequest),
      .av_read            (av_read),
      .av_write           (av_write),
      .av_begintransfer   (av_begintransfer),
      .av_writebyteenable (av_writebyteenable),
      .read_accepted      (read_accepted)
   );

   // ------------------------------------------------------------------------
   // read return
   // ------------------------------------------------------------------------
   read_return_pipe u_read_return_pipe (
      .clk           (clk),
      .reset         (reset),
      .read_accepted (read_accepted),
      .readdatavalid (uav_readdatavalid)
   );

endmodule

// ==== source/read_return_pipe.sv ====
// fixed-latency return only; the downstream slave can never stall or reorder data
`timescale 1ns/1ps
`include "xlat_config.svh"

module read_return_pipe (
   input  logic clk,
   input  logic reset,
   input  logic read_accepted,
   output logic readdatavalid
);

   localparam int LAT = `XLAT_READ_LATENCY;

   // one bit per cycle of latency, several reads may be in flight
   logic [LAT-1:0] stages;

   generate
      if (LAT < 1) begin : g_bad_latency
         $error("read latency must be at least 1");
      end
   endgenerate

   // ------------------------------------------------------------------------
   // latency shift register
   // ------------------------------------------------------------------------
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         stages <= '0;
      end else begin
         stages[0] <= read_accepted;
         for (int i = 1; i < LAT; i++) begin
            stages[i] <= stages[i-1];
         end
      end
   end

   // oldest stage lines up with av_readdata from the slave
   assign readdatavalid = stages[LAT-1];

endmodule

// ==== source/access_timer.sv ====
// master must hold read or write stable under waitrequest and never raise both at once
`timescale 1ns/1ps
`include "xlat_config.svh"

module access_timer (
   input  logic              clk,
   input  logic              reset,
   input  logic              read,
   input  logic              write,
   input  xlat_pkg::byteen_t byteenable,
   output logic              waitrequest,
   output logic              av_read,
   output logic              av_write,
   output logic              av_begintransfer,
   output xlat_pkg::byteen_t av_writebyteenable,
   output logic              read_accepted
);

   // phase lengths; the done cycle is the last cycle of every access
   localparam int SETUP_LEN     = `XLAT_SETUP_CYCLES;
   localparam int RD_STROBE_LEN = `XLAT_READ_WAIT_CYCLES;
   localparam int WR_STROBE_LEN = `XLAT_WRITE_WAIT_CYCLES + ((`XLAT_HOLD_CYCLES != 0) ? 1 : 0);
   localparam int WR_HOLD_LEN   = (`XLAT_HOLD_CYCLES != 0) ? `XLAT_HOLD_CYCLES - 1 : 0;
   localparam int CNT_W         = $clog2(`XLAT_SETUP_CYCLES + `XLAT_READ_WAIT_CYCLES +
                                         `XLAT_WRITE_WAIT_CYCLES + `XLAT_HOLD_CYCLES + 2);

   xlat_pkg::access_kind_e  kind;
   xlat_pkg::access_phase_e phase_q;
   xlat_pkg::access_phase_e cur_phase;
   xlat_pkg::access_phase_e nxt_phase;
   logic [CNT_W-1:0]        cnt_q;
   logic [CNT_W-1:0]        cur_cnt;
   logic [CNT_W-1:0]        nxt_cnt;
   logic                    reset_override;
   logic                    begin_done;

   function automatic logic [CNT_W-1:0] phase_len(input xlat_pkg::access_phase_e ph,
                                                  input xlat_pkg::access_kind_e kd);
      int len;
      case (ph)
         xlat_pkg::PH_SETUP:  len = SETUP_LEN;
         xlat_pkg::PH_STROBE: len = (kd == xlat_pkg::ACC_WRITE) ? WR_STROBE_LEN : RD_STROBE_LEN;
         xlat_pkg::PH_HOLD:   len = (kd == xlat_pkg::ACC_WRITE) ? WR_HOLD_LEN : 0;
         xlat_pkg::PH_DONE:   len = 1;
         default:             len = 0;
      endcase
      return CNT_W'(len);
   endfunction

   // first non-empty phase after ph
   function automatic xlat_pkg::access_phase_e next_phase(input xlat_pkg::access_phase_e ph,
                                                          input xlat_pkg::access_kind_e kd);
      xlat_pkg::access_phase_e nxt;
      if (ph == xlat_pkg::PH_DONE)
         nxt = xlat_pkg::PH_IDLE;
      else if (ph == xlat_pkg::PH_IDLE && phase_len(xlat_pkg::PH_SETUP, kd) != '0)
         nxt = xlat_pkg::PH_SETUP;
      else if (ph inside {xlat_pkg::PH_IDLE, xlat_pkg::PH_SETUP} &&
               phase_len(xlat_pkg::PH_STROBE, kd) != '0)
         nxt = xlat_pkg::PH_STROBE;
      else if (ph != xlat_pkg::PH_HOLD && phase_len(xlat_pkg::PH_HOLD, kd) != '0)
         nxt = xlat_pkg::PH_HOLD;
      else
         nxt = xlat_pkg::PH_DONE;
      return nxt;
   endfunction

   // ------------------------------------------------------------------------
   // request decode and current phase
   // ------------------------------------------------------------------------
   always_comb begin
      kind = xlat_pkg::ACC_NONE;
      if (read)
         kind = xlat_pkg::ACC_READ;
      else if (write)
         kind = xlat_pkg::ACC_WRITE;
   end

   // an idle timer enters the first phase in the request's own first cycle
   always_comb begin
      cur_phase = phase_q;
      cur_cnt   = cnt_q;
      if (phase_q == xlat_pkg::PH_IDLE) begin
         cur_cnt   = '0;
         cur_phase = xlat_pkg::PH_IDLE;
         if (kind != xlat_pkg::ACC_NONE && !reset_override)
            cur_phase = next_phase(xlat_pkg::PH_IDLE, kind);
      end
   end

   always_comb begin
      nxt_phase = cur_phase;
      nxt_cnt   = cur_cnt + 1'b1;
      if (cur_phase == xlat_pkg::PH_IDLE) begin
         nxt_cnt = '0;
      end else if (cur_cnt == phase_len(cur_phase, kind) - 1'b1) begin
         nxt_phase = next_phase(cur_phase, kind);
         nxt_cnt   = '0;
      end
   end

   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         phase_q        <= xlat_pkg::PH_IDLE;
         cnt_q          <= '0;
         reset_override <= 1'b1;
         begin_done     <= 1'b0;
      end else begin
         phase_q        <= nxt_phase;
         cnt_q          <= nxt_cnt;
         reset_override <= 1'b0;
         // one begin pulse per access, rearmed when the access completes
         if (!waitrequest)
            begin_done <= 1'b0;
         else if (av_begintransfer)
            begin_done <= 1'b1;
      end
   end

   // ------------------------------------------------------------------------
   // downstream strobes and upstream handshake
   // ------------------------------------------------------------------------
   assign waitrequest = reset_override | (cur_phase != xlat_pkg::PH_DONE);

   assign av_read = (kind == xlat_pkg::ACC_READ) &&
                    (cur_phase inside {xlat_pkg::PH_STROBE, xlat_pkg::PH_DONE});

   // with no hold time the done cycle is still a write cycle
   assign av_write = (kind == xlat_pkg::ACC_WRITE) &&
                     ((cur_phase == xlat_pkg::PH_STROBE) ||
                      (cur_phase == xlat_pkg::PH_DONE && `XLAT_HOLD_CYCLES == 0));

   assign av_begintransfer   = (read | write) & ~begin_done & ~reset_override;
   assign av_writebyteenable = byteenable & {`XLAT_SYMBOLS_PER_WORD{write}};
   assign read_accepted      = (kind == xlat_pkg::ACC_READ) && (cur_phase == xlat_pkg::PH_DONE);

endmodule

// ==== source/xlat_pkg.sv ====
// types follow the widths in xlat_config.svh; the enum encodings are internal only
`include "xlat_config.svh"

package xlat_pkg;

   // -------------------------------------------------------------------------
   // bus payload types
   // -------------------------------------------------------------------------
   typedef logic [`XLAT_DATA_W-1:0]           data_t;
   typedef logic [`XLAT_SYMBOLS_PER_WORD-1:0] byteen_t;
   typedef logic [`XLAT_UAV_ADDR_W-1:0]       uav_addr_t;
   typedef logic [`XLAT_AV_ADDR_W-1:0]        av_addr_t;

   // decoded upstream request
   typedef enum logic [1:0] {
      ACC_NONE,
      ACC_READ,
      ACC_WRITE
   } access_kind_e;

   // timer state, one access walks setup, strobe, hold, done
   typedef enum logic [2:0] {
      PH_IDLE,
      PH_SETUP,
      PH_STROBE,
      PH_HOLD,
      PH_DONE
   } access_phase_e;

endpackage

// ==== source/xlat_config.svh ====
// timing macros fix one slave configuration; XLAT_READ_LATENCY must be at least 1
`ifndef XLAT_CONFIG_SVH
`define XLAT_CONFIG_SVH

// ---------------------------------------------------------------------------
// bus widths
// ---------------------------------------------------------------------------
`define XLAT_DATA_W            32
`define XLAT_SYMBOLS_PER_WORD  4
`define XLAT_WORD_SHIFT        2
`define XLAT_UAV_ADDR_W        32
`define XLAT_AV_ADDR_W         30

// ---------------------------------------------------------------------------
// downstream slave timing, in clock cycles
// ---------------------------------------------------------------------------
`define XLAT_SETUP_CYCLES      1
`define XLAT_READ_WAIT_CYCLES  2
`define XLAT_WRITE_WAIT_CYCLES 1
`define XLAT_HOLD_CYCLES       1

// fixed read latency, counted from the last av_read cycle
`define XLAT_READ_LATENCY      2

`endif
